// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = video_mon_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
rtl/video_mon_pkg.sv
rtl/axi4s_if.sv
rtl/frame_stat_if.sv
rtl/video_pattern_gen.sv
rtl/stream_monitor.sv
rtl/frame_format_checker.sv
rtl/video_mon_top.sv
verif/video_mon_tb.sv

// ==== rtl/axi4s_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Stream video link.
// tuser marks frame start, tlast ends a line.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface axi4s_if;

    video_mon_pkg::data_t tdata;
    logic                 tuser;
    logic                 tlast;
    logic                 tvalid;
    logic                 tready;

    // pixel source side.
    modport src (
        output tdata,
        output tuser,
        output tlast,
        output tvalid,
        input  tready
    );

    // downstream sink only gives ready.
    modport snk (
        output tready
    );

    // passive observer.
    modport mon (
        input tdata,
        input tuser,
        input tlast,
        input tvalid,
        input tready
    );

endinterface

`default_nettype wire

// ==== rtl/frame_format_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame format checker.
// counts frames and geometry changes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module frame_format_checker (
    input  logic                      mon_axi4s,
    input  logic                      reset,
    frame_stat_if.dst                 stat,
    output logic                      stat_valid,
    output video_mon_pkg::count_t     frame_count,
    output video_mon_pkg::count_t     format_changes,
    output video_mon_pkg::x_t         last_width,
    output video_mon_pkg::y_t         last_height,
    output video_mon_pkg::pixel_cnt_t last_pixels
);

    logic geometry_differs;

    assign geometry_differs = (stat.width != last_width) || (stat.height != last_height);

    always_ff @(posedge mon_axi4s) begin
        if (reset) begin
            stat_valid     <= 1'b0;
            frame_count    <= '0;
            format_changes <= '0;
            last_width     <= '0;
            last_height    <= '0;
            last_pixels    <= '0;
        end else begin
            stat_valid <= stat.frame_done;

            if (stat.frame_done) begin
                frame_count <= frame_count + 1'b1;
                last_width  <= stat.width;
                last_height <= stat.height;
                last_pixels <= stat.pixels;

                // no previous frame to compare against on the first report.
                if (frame_count != '0 && geometry_differs) begin
                    format_changes <= format_changes + 1'b1;
                end
            end
        end
    end

    // the monitor numbers frames from 1, so no report may be skipped.
    a_frame_sequence : assert property (
        @(posedge mon_axi4s) disable iff (reset)
        stat.frame_done |-> (stat.frame == video_mon_pkg::count_t'(frame_count + 1'b1))
    ) else $error("frame report out of sequence");

endmodule

`default_nettype wire

// ==== rtl/frame_stat_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-frame report from the stream monitor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface frame_stat_if;

    // single-cycle strobe, values valid with it.
    logic                      frame_done;
    video_mon_pkg::x_t         width;
    video_mon_pkg::y_t         height;
    video_mon_pkg::pixel_cnt_t pixels;
    video_mon_pkg::count_t     frame;

    modport src (
        output frame_done,
        output width,
        output height,
        output pixels,
        output frame
    );

    modport dst (
        input frame_done,
        input width,
        input height,
        input pixels,
        input frame
    );

endinterface

`default_nettype wire

// ==== rtl/stream_monitor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// passive AXI4-Stream monitor.
// counts position and geometry, reports each frame.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module stream_monitor (
    input  logic                  mon_axi4s,
    input  logic                  reset,
    axi4s_if.mon                  axi4s,
    frame_stat_if.src             stat,
    output video_mon_pkg::timer_t timer
);

    logic beat;

    video_mon_pkg::pixel_cnt_t pixel;
    video_mon_pkg::count_t     frame;
    video_mon_pkg::x_t         x;
    video_mon_pkg::y_t         y;
    video_mon_pkg::x_t         width;
    video_mon_pkg::y_t         height;

    assign beat = axi4s.tvalid && axi4s.tready;

    always_ff @(posedge mon_axi4s) begin
        if (reset) begin
            timer  <= '0;
            pixel  <= '0;
            frame  <= '0;
            x      <= '0;
            y      <= '0;
            width  <= '0;
            height <= '0;
        end else begin
            timer <= timer + 1'b1;

            if (beat) begin
                pixel <= pixel + 1'b1;
                x     <= x + 1'b1;

                if (axi4s.tlast) begin
                    x     <= '0;
                    y     <= y + 1'b1;
                    width <= x + 1'b1;
                end

                // frame start wins over the line end.
                if (axi4s.tuser) begin
                    frame  <= frame + 1'b1;
                    pixel  <= '0;
                    height <= y;
                    // a one pixel wide line already ends here.
                    y      <= axi4s.tlast ? video_mon_pkg::y_t'(1) : '0;
                end
            end
        end
    end

    // the report samples the counters before the new frame overwrites them.
    always_ff @(posedge mon_axi4s) begin
        if (reset) begin
            stat.frame_done <= 1'b0;
        end else begin
            stat.frame_done <= beat && axi4s.tuser && (frame != '0);
        end
    end

    always_ff @(posedge mon_axi4s) begin
        if (beat && axi4s.tuser) begin
            stat.width  <= width;
            // pixel is the index of the last beat.
            stat.pixels <= pixel + 1'b1;
            stat.frame  <= frame;
        end
    end

    // height is latched at the frame start, together with the other report values.
    assign stat.height = height;

    a_x_in_range : assert property (
        @(posedge mon_axi4s) disable iff (reset)
        axi4s.tvalid |-> (x != '1)
    ) else $error("line longer than x counter range");

endmodule

`default_nettype wire

// ==== rtl/video_mon_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video monitor package.
// widths and types shared by the stream blocks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package video_mon_pkg;

    // raster geometry.
    localparam int X_BITS     = 12;
    localparam int Y_BITS     = 12;

    // pixel payload holds {y, x}.
    localparam int DATA_BITS  = 24;

    // measurement counters.
    localparam int TIMER_BITS = 32;
    localparam int PIXEL_BITS = 24;
    localparam int COUNT_BITS = 16;

    typedef logic [X_BITS-1:0]     x_t;
    typedef logic [Y_BITS-1:0]     y_t;
    typedef logic [DATA_BITS-1:0]  data_t;
    typedef logic [TIMER_BITS-1:0] timer_t;
    typedef logic [PIXEL_BITS-1:0] pixel_cnt_t;
    typedef logic [COUNT_BITS-1:0] count_t;

    // pattern generator states.
    typedef enum logic [0:0] {
        idle,
        run
    } gen_state_t;

endpackage

`default_nettype wire

// ==== rtl/video_mon_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video measurement top.
// pattern source, stream monitor and format checker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module video_mon_top (
    input  logic                      mon_axi4s,
    input  logic                      reset,

    // pattern control.
    input  logic                      start,
    input  video_mon_pkg::x_t         cfg_width,
    input  video_mon_pkg::y_t         cfg_height,
    output logic                      busy,

    // observed stream.
    input  logic                      tready,
    output video_mon_pkg::data_t      tdata,
    output logic                      tuser,
    output logic                      tlast,
    output logic                      tvalid,

    // measurements.
    output video_mon_pkg::timer_t     timer,
    output logic                      stat_valid,
    output video_mon_pkg::count_t     frame_count,
    output video_mon_pkg::count_t     format_changes,
    output video_mon_pkg::x_t         last_width,
    output video_mon_pkg::y_t         last_height,
    output video_mon_pkg::pixel_cnt_t last_pixels
);

    axi4s_if      axi4s ();
    frame_stat_if stat ();

    // ready comes from outside the design.
    assign axi4s.tready = tready;

    assign tdata  = axi4s.tdata;
    assign tuser  = axi4s.tuser;
    assign tlast  = axi4s.tlast;
    assign tvalid = axi4s.tvalid;

    video_pattern_gen u_gen (
        .mon_axi4s  (mon_axi4s),
        .reset      (reset),
        .start      (start),
        .cfg_width  (cfg_width),
        .cfg_height (cfg_height),
        .busy       (busy),
        .axi4s      (axi4s.src)
    );

    stream_monitor u_mon (
        .mon_axi4s (mon_axi4s),
        .reset     (reset),
        .axi4s     (axi4s.mon),
        .stat      (stat.src),
        .timer     (timer)
    );

    frame_format_checker u_chk (
        .mon_axi4s      (mon_axi4s),
        .reset          (reset),
        .stat           (stat.dst),
        .stat_valid     (stat_valid),
        .frame_count    (frame_count),
        .format_changes (format_changes),
        .last_width     (last_width),
        .last_height    (last_height),
        .last_pixels    (last_pixels)
    );

endmodule

`default_nettype wire

// ==== rtl/video_pattern_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test pattern source.
// one raster frame per start, data is {y, x}.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module video_pattern_gen (
    input  logic                 mon_axi4s,
    input  logic                 reset,
    input  logic                 start,
    input  video_mon_pkg::x_t    cfg_width,
    input  video_mon_pkg::y_t    cfg_height,
    output logic                 busy,
    axi4s_if.src                 axi4s
);

    video_mon_pkg::gen_state_t state;

    video_mon_pkg::x_t x;
    video_mon_pkg::y_t y;

    // geometry captured at start.
    video_mon_pkg::x_t width_q;
    video_mon_pkg::y_t height_q;

    logic line_end;
    logic frame_end;

    assign line_end  = (x == width_q - 1'b1);
    assign frame_end = line_end && (y == height_q - 1'b1);

    always_ff @(posedge mon_axi4s) begin
        if (reset) begin
            state <= video_mon_pkg::idle;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                video_mon_pkg::idle: begin
                    if (start) begin
                        state <= video_mon_pkg::run;
                        x     <= '0;
                        y     <= '0;
                    end
                end
                video_mon_pkg::run: begin
                    // advance only when the beat is taken.
                    if (axi4s.tready) begin
                        if (line_end) begin
                            x <= '0;
                            if (frame_end) begin
                                y     <= '0;
                                state <= video_mon_pkg::idle;
                            end else begin
                                y <= y + 1'b1;
                            end
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= video_mon_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge mon_axi4s) begin
        if (state == video_mon_pkg::idle && start) begin
            width_q  <= cfg_width;
            height_q <= cfg_height;
        end
    end

    // outputs come straight from state, so they hold while stalled.
    assign busy         = (state == video_mon_pkg::run);
    assign axi4s.tvalid = (state == video_mon_pkg::run);
    assign axi4s.tuser  = (state == video_mon_pkg::run) && (x == '0) && (y == '0);
    assign axi4s.tlast  = (state == video_mon_pkg::run) && line_end;
    assign axi4s.tdata  = video_mon_pkg::data_t'({y, x});

    a_hold_when_stalled : assert property (
        @(posedge mon_axi4s) disable iff (reset)
        (axi4s.tvalid && !axi4s.tready) |=> (axi4s.tvalid && $stable(axi4s.tdata))
    ) else $error("stalled beat changed before transfer");

endmodule

`default_nettype wire

// ==== verif/video_mon_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video measurement testbench.
// random ready, frame model and stream checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module video_mon_tb;

    localparam int NUM_FRAMES  = 6;
    localparam int EXP_CHANGES = 2;

    // frame sequence, the last one only flushes the previous report.
    int frame_w [NUM_FRAMES] = '{8, 8, 5, 5, 16, 1};
    int frame_h [NUM_FRAMES] = '{4, 4, 3, 3, 2, 1};

    logic                      mon_axi4s;
    logic                      reset;
    logic                      start;
    video_mon_pkg::x_t         cfg_width;
    video_mon_pkg::y_t         cfg_height;
    logic                      busy;
    logic                      tready;
    video_mon_pkg::data_t      tdata;
    logic                      tuser;
    logic                      tlast;
    logic                      tvalid;
    video_mon_pkg::timer_t     timer;
    logic                      stat_valid;
    video_mon_pkg::count_t     frame_count;
    video_mon_pkg::count_t     format_changes;
    video_mon_pkg::x_t         last_width;
    video_mon_pkg::y_t         last_height;
    video_mon_pkg::pixel_cnt_t last_pixels;

    // reference model state.
    video_mon_pkg::x_t     exp_x;
    video_mon_pkg::y_t     exp_y;
    video_mon_pkg::data_t  exp_data;
    video_mon_pkg::timer_t prev_timer;
    logic                  prev_reset;
    int                    cur_w;
    int                    cur_h;
    int                    frame_beats;
    int                    reports_seen;
    int                    frames_started;

    integer seed = 32'hdc44373c;
    string  test_name;
    int     error_count;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;
    int     cycle_limit;

    video_mon_top UUT (
        .mon_axi4s      (mon_axi4s),
        .reset          (reset),
        .start          (start),
        .cfg_width      (cfg_width),
        .cfg_height     (cfg_height),
        .busy           (busy),
        .tready         (tready),
        .tdata          (tdata),
        .tuser          (tuser),
        .tlast          (tlast),
        .tvalid         (tvalid),
        .timer          (timer),
        .stat_valid     (stat_valid),
        .frame_count    (frame_count),
        .format_changes (format_changes),
        .last_width     (last_width),
        .last_height    (last_height),
        .last_pixels    (last_pixels)
    );

    initial begin
        mon_axi4s = 1'b0;
        forever #5 mon_axi4s = ~mon_axi4s;
    end

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %s: %s", test_name, what);
        error_count++;
        test_errors++;
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            value_error(what, expected, actual);
        end
    endtask

    task automatic end_test();
        $display("test %-16s %s (%0d errors)", test_name,
                 (test_errors == 0) ? "pass" : "fail", test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // format changes among the first n+1 reports.
    function automatic int changes_through(input int n);
        int c;
        int i;
        c = 0;
        for (i = 1; i <= n; i++) begin
            if (frame_w[i] != frame_w[i-1] || frame_h[i] != frame_h[i-1]) begin
                c++;
            end
        end
        return c;
    endfunction

    task automatic run_frame(input int k);
        test_name = $sformatf("frame%0d_%0dx%0d", k, frame_w[k], frame_h[k]);
        @(posedge mon_axi4s);
        cfg_width      <= video_mon_pkg::x_t'(frame_w[k]);
        cfg_height     <= video_mon_pkg::y_t'(frame_h[k]);
        start          <= 1'b1;
        cur_w          <= frame_w[k];
        cur_h          <= frame_h[k];
        frames_started <= frames_started + 1;
        @(posedge mon_axi4s);
        start <= 1'b0;
        @(negedge mon_axi4s);
        if (!busy) begin
            report_failure("busy did not rise after start");
        end
        while (busy) begin
            @(negedge mon_axi4s);
        end
        // one more edge so the beat count check lands in this test.
        @(posedge mon_axi4s);
        @(negedge mon_axi4s);
        end_test();
    endtask

    // random back-pressure, ready about three beats in four.
    always @(posedge mon_axi4s) begin
        tready <= (($random(seed) & 3) != 0);
    end

    // expected raster position, advanced on each accepted beat.
    always @(posedge mon_axi4s) begin
        if (reset) begin
            exp_x       <= '0;
            exp_y       <= '0;
            frame_beats <= 0;
        end else if (tvalid && tready) begin
            if (exp_x == '0 && exp_y == '0) begin
                frame_beats <= 1;
            end else begin
                frame_beats <= frame_beats + 1;
            end
            if (exp_x == video_mon_pkg::x_t'(cur_w - 1)) begin
                exp_x <= '0;
                if (exp_y == video_mon_pkg::y_t'(cur_h - 1)) begin
                    exp_y <= '0;
                end else begin
                    exp_y <= exp_y + 1'b1;
                end
            end else begin
                exp_x <= exp_x + 1'b1;
            end
        end
    end

    assign exp_data = video_mon_pkg::data_t'({exp_y, exp_x});

    always @(posedge mon_axi4s) begin
        prev_timer <= timer;
        prev_reset <= reset;
        if (reset) begin
            reports_seen <= 0;
        end else if (stat_valid) begin
            reports_seen <= reports_seen + 1;
        end
    end

    a_first_beat : assert property (@(posedge mon_axi4s) disable iff (reset)
        tvalid |-> (tuser == (exp_x == '0 && exp_y == '0)))
        else value_error("tuser", 32'(!$sampled(tuser)), 32'($sampled(tuser)));

    a_line_end : assert property (@(posedge mon_axi4s) disable iff (reset)
        tvalid |-> (tlast == (exp_x == video_mon_pkg::x_t'(cur_w - 1))))
        else value_error("tlast", 32'(!$sampled(tlast)), 32'($sampled(tlast)));

    a_pixel_data : assert property (@(posedge mon_axi4s) disable iff (reset)
        tvalid |-> (tdata == exp_data))
        else value_error("tdata", 32'($sampled(exp_data)), 32'($sampled(tdata)));

    a_beat_count : assert property (@(posedge mon_axi4s) disable iff (reset)
        $fell(busy) |-> (frame_beats == cur_w * cur_h))
        else value_error("beats", 32'($sampled(cur_w) * $sampled(cur_h)),
                         32'($sampled(frame_beats)));

    a_stall_hold : assert property (@(posedge mon_axi4s) disable iff (reset)
        (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast)))
        else report_failure("stalled beat changed before it was accepted");

    a_report_width : assert property (@(posedge mon_axi4s) disable iff (reset)
        stat_valid |-> (last_width == video_mon_pkg::x_t'(frame_w[reports_seen])))
        else value_error("last_width", 32'(frame_w[$sampled(reports_seen)]),
                         32'($sampled(last_width)));

    a_report_height : assert property (@(posedge mon_axi4s) disable iff (reset)
        stat_valid |-> (last_height == video_mon_pkg::y_t'(frame_h[reports_seen])))
        else value_error("last_height", 32'(frame_h[$sampled(reports_seen)]),
                         32'($sampled(last_height)));

    a_report_pixels : assert property (@(posedge mon_axi4s) disable iff (reset)
        stat_valid |-> (last_pixels ==
            video_mon_pkg::pixel_cnt_t'(frame_w[reports_seen] * frame_h[reports_seen])))
        else value_error("last_pixels",
                         32'(frame_w[$sampled(reports_seen)] * frame_h[$sampled(reports_seen)]),
                         32'($sampled(last_pixels)));

    a_report_count : assert property (@(posedge mon_axi4s) disable iff (reset)
        stat_valid |-> (frame_count == video_mon_pkg::count_t'(reports_seen + 1)))
        else value_error("frame_count", 32'($sampled(reports_seen) + 1),
                         32'($sampled(frame_count)));

    a_report_changes : assert property (@(posedge mon_axi4s) disable iff (reset)
        stat_valid |-> (format_changes == video_mon_pkg::count_t'(changes_through(reports_seen))))
        else value_error("format_changes", 32'(changes_through($sampled(reports_seen))),
                         32'($sampled(format_changes)));

    // the timer never stalls, also not under back-pressure.
    a_timer_step : assert property (@(posedge mon_axi4s) disable iff (reset)
        !prev_reset |-> (timer == prev_timer + 32'd1))
        else value_error("timer", 32'($sampled(prev_timer) + 32'd1), 32'($sampled(timer)));

    always @(posedge mon_axi4s) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int total_pixels;
        int k;
        reset          = 1'b1;
        start          = 1'b0;
        cfg_width      = '0;
        cfg_height     = '0;
        tready         = 1'b0;
        cur_w          = 0;
        cur_h          = 0;
        frames_started = 0;
        error_count    = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        cycle_count    = 0;
        total_pixels   = 0;
        for (k = 0; k < NUM_FRAMES; k++) begin
            total_pixels += frame_w[k] * frame_h[k];
        end
        // ready rate is about 3/4, plus start and report overhead per frame.
        cycle_limit = (4 * total_pixels * 4) / 3 + 40 * NUM_FRAMES + 10;

        repeat (4) @(posedge mon_axi4s);
        reset <= 1'b0;
        @(negedge mon_axi4s);
        test_name = "reset";
        compare_value("timer", 0, timer);
        compare_value("tvalid", 0, 32'(tvalid));
        compare_value("busy", 0, 32'(busy));
        compare_value("stat_valid", 0, 32'(stat_valid));
        compare_value("frame_count", 0, 32'(frame_count));
        compare_value("format_changes", 0, 32'(format_changes));
        compare_value("last_width", 0, 32'(last_width));
        compare_value("last_height", 0, 32'(last_height));
        compare_value("last_pixels", 0, 32'(last_pixels));
        end_test();

        for (k = 0; k < NUM_FRAMES; k++) begin
            run_frame(k);
        end

        test_name = "totals";
        while (reports_seen < NUM_FRAMES - 1) begin
            @(negedge mon_axi4s);
        end
        // a few idle cycles, no extra report may show up.
        repeat (3) @(negedge mon_axi4s);
        compare_value("frame_count", NUM_FRAMES - 1, 32'(frame_count));
        compare_value("format_changes", EXP_CHANGES, 32'(format_changes));
        compare_value("reports", frames_started - 1, reports_seen);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
